// File: verif/pipe_vectors.hex
// instruction word (opcode, rd, unused, operands) _ expected rd _ expected value
// one instruction per line, in program order
// ALU and immediate opcodes
00801234_01_0046
0100ffff_02_01fe
11805020_03_0030
12000001_04_ffff
128010ff_05_ff11
2300f03c_06_0030
3380a5ff_07_005a
5400beef_08_beef
5f800000_1f_0000
// multiply edge operands
448000ff_09_0000
4500ffff_0a_fe01
4580ff00_0b_0000
// unused opcodes
f6001234_0c_0000
66801111_0d_0000
// multiply overtaken by ALU work
47000c0d_0e_009c
07800102_0f_0003
380055aa_10_00ff
58801234_11_1234
29000fff_12_000f
// multiply burst
49800305_13_000f
4a001010_14_0100
4a808002_15_0100
4b007f81_16_3fff
4b80ff01_17_00ff
4c0001ff_18_00ff
4c80aa55_19_3872
4d00c864_1a_4e20
4d800ff0_1b_0e10
4e00fefd_1c_fb06
// tail of mixed work
0e807f01_1d_0080
1f000102_1e_ffff
3000ffff_00_0000
5080ffff_01_ffff
41000909_02_0051
2180ff81_03_0081
02000000_04_0000

// File: tb.f
logic/pipe_pkg.sv
logic/dispatch.sv
logic/exec_lane.sv
logic/rob.sv
logic/pipeline.sv
verif/pipeline_tb.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := pipeline_tb
FILELIST := tb.f
OBJDIR   := obj_dir
LOG      := sim.log

SOURCES  := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "Testbench failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: verif/pipeline_tb.sv
module pipeline_tb
  import pipe_pkg::*;
();

  localparam int VEC_COUNT      = 36;
  localparam int VEC_AW         = $clog2(VEC_COUNT);
  localparam int CLK_PERIOD     = 100;
  localparam int DRIVE_DELAY    = 10;
  localparam int TIMEOUT_CYCLES = VEC_COUNT * 20 + 100;

  logic    clock;
  logic    rst_n;
  logic    in_valid;
  instr_t  in_instr;
  logic    stall;
  retire_t retire;

  // Instruction word, expected rd byte, expected value
  logic [55:0] vectors [VEC_COUNT];

  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          issued;
  int          retired;
  int          stall_cycles;

  pipeline DUT(
    // Outputs
    .stall    (stall),
    .retire   (retire),
    // Inputs
    .clock    (clock),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_instr (in_instr));

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // Retires must match the vectors one by one in program order
  always @(negedge clock) begin
    logic [55:0] vec;
    if (rst_n && retire.valid) begin
      if (retired >= issued) begin
        errors++;
        $display("unexpected retire at time %0t with no instruction outstanding", $time);
      end else begin
        vec = vectors[VEC_AW'(retired)];
        check_value("retire.rd", 32'(retire.rd), 32'(vec[23:16]));
        check_value("retire.value", 32'(retire.value), 32'(vec[15:0]));
        retired++;
      end
    end
  end

  initial begin
    logic [55:0] vec;
    instr_t      next_instr;
    int          gap;
    logic        prev_mul;
    logic        taken;

    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_instr     = '0;
    rng_state    = 32'h28ef_f1c7;
    errors       = 0;
    checks       = 0;
    issued       = 0;
    retired      = 0;
    stall_cycles = 0;
    prev_mul     = 1'b0;
    $readmemh("verif/pipe_vectors.hex", vectors);

    repeat (2) @(posedge clock);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    check_value("stall", 32'(stall), 32'd0);
    check_value("retire.valid", 32'(retire.valid), 32'd0);

    // Idle a few cycles so a spurious retire would show
    repeat (3) begin
      @(posedge clock);
      #DRIVE_DELAY;
    end

    for (int n = 0; n < VEC_COUNT; n++) begin
      vec        = vectors[VEC_AW'(n)];
      next_instr = vec[55:24];

      rng_state = xorshift(rng_state);
      gap       = int'(rng_state % 32'd4);
      // Multiply bursts go back to back to fill the lanes
      if (prev_mul && next_instr.opcode == op_mul) begin
        gap = 0;
      end
      repeat (gap) begin
        @(posedge clock);
        #DRIVE_DELAY;
      end

      in_valid = 1'b1;
      in_instr = next_instr;
      // stall only changes on clock edges
      do begin
        taken = !stall;
        if (stall) begin
          stall_cycles++;
        end
        @(posedge clock);
        #DRIVE_DELAY;
      end while (!taken);
      in_valid = 1'b0;
      issued++;
      prev_mul = next_instr.opcode == op_mul;
    end

    wait (retired == VEC_COUNT);
    repeat (5) begin
      @(posedge clock);
      #DRIVE_DELAY;
    end
    check_value("stall", 32'(stall), 32'd0);

    if (stall_cycles == 0) begin
      errors++;
      $display("stall never went high during the multiply burst");
    end

    $display("%0d checks, %0d errors, %0d retired, %0d stall cycles",
             checks, errors, retired, stall_cycles);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles with %0d of %0d instructions retired",
             TIMEOUT_CYCLES, retired, VEC_COUNT);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: logic/pipeline.sv
module pipeline
  import pipe_pkg::*;
(
  input           clock,
  input           rst_n,

  // instruction input
  input           in_valid,
  input  instr_t  in_instr,

  // status and retire report
  output logic    stall,
  output retire_t retire
);

  logic [NUM_LANES-1:0]         lane_busy;
  logic                         rob_full;
  rob_alloc_t                   alloc;
  lane_issue_t  [NUM_LANES-1:0] issue;
  lane_result_t [NUM_LANES-1:0] results;

  dispatch DISPATCH(
    // Outputs
    .stall      (stall),
    .alloc      (alloc),
    .issue      (issue),
    // Inputs
    .clock      (clock),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .lane_busy  (lane_busy),
    .rob_full   (rob_full));

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    exec_lane LANE(
      // Outputs
      .busy     (lane_busy[i]),
      .result   (results[i]),
      // Inputs
      .clock    (clock),
      .rst_n    (rst_n),
      .issue    (issue[i]));
  end

  rob ROB(
    // Outputs
    .full       (rob_full),
    .retire     (retire),
    // Inputs
    .clock      (clock),
    .rst_n      (rst_n),
    .alloc      (alloc),
    .results    (results));

endmodule

// File: logic/rob.sv
module rob
  import pipe_pkg::*;
(
  input                                 clock,
  input                                 rst_n,

  // from dispatch
  input  rob_alloc_t                    alloc,

  // from lanes
  input  lane_result_t [NUM_LANES-1:0]  results,

  // to dispatch and outside
  output logic                          full,
  output retire_t                       retire
);

  logic [REG_W-1:0]  ent_rd   [ROB_DEPTH];
  logic [VAL_W-1:0]  ent_val  [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] ent_done;

  logic [SLOT_W-1:0] head;
  logic [SLOT_W:0]   count;
  logic              can_retire;

  logic              retire_valid;
  logic [REG_W-1:0]  retire_rd;
  logic [VAL_W-1:0]  retire_val;

  assign full       = count == (SLOT_W + 1)'(ROB_DEPTH);
  assign can_retire = (count != '0) && ent_done[head];

  assign retire.valid = retire_valid;
  assign retire.rd    = retire_rd;
  assign retire.value = retire_val;

  // Done flags, pointers and the retire strobe
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ent_done     <= '0;
      head         <= '0;
      count        <= '0;
      retire_valid <= 1'b0;
    end else begin
      if (alloc.valid) begin
        ent_done[alloc.slot] <= 1'b0;
      end
      for (int i = 0; i < NUM_LANES; i++) begin
        if (results[i].valid) begin
          ent_done[results[i].slot] <= 1'b1;
        end
      end

      retire_valid <= can_retire;
      if (can_retire) begin
        head <= head + SLOT_W'(1);
      end
      count <= count + (SLOT_W + 1)'(alloc.valid) - (SLOT_W + 1)'(can_retire);
    end
  end

  // Entry payload
  always_ff @(posedge clock) begin
    if (alloc.valid) begin
      ent_rd[alloc.slot] <= alloc.rd;
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      if (results[i].valid) begin
        ent_val[results[i].slot] <= results[i].value;
      end
    end
    if (can_retire) begin
      retire_rd  <= ent_rd[head];
      retire_val <= ent_val[head];
    end
  end

endmodule

// File: logic/exec_lane.sv
module exec_lane
  import pipe_pkg::*;
(
  input                clock,
  input                rst_n,

  // from dispatch
  input  lane_issue_t  issue,

  // to dispatch and ROB
  output logic         busy,
  output lane_result_t result
);

  logic              active;
  logic [STEP_W-1:0] step;
  instr_t            instr_q;
  logic [SLOT_W-1:0] slot_q;

  // Multiplier state
  logic [VAL_W-1:0]  acc;
  logic [VAL_W-1:0]  mcand;
  logic [OPND_W-1:0] mplier;

  logic              is_mul;
  logic              done;
  logic              mul_run;
  logic [VAL_W-1:0]  a;
  logic [VAL_W-1:0]  b;
  logic [VAL_W-1:0]  value;

  assign is_mul  = instr_q.opcode == op_mul;
  assign done    = active && (!is_mul || step == STEP_W'(MUL_STEPS - 1));
  assign mul_run = active && is_mul && !done;

  // Free again on the edge that writes the result
  assign busy = active && !done;

  assign a = VAL_W'(instr_q.operand.ops.opa);
  assign b = VAL_W'(instr_q.operand.ops.opb);

  always_comb begin
    case (instr_q.opcode)
      op_add:  value = a + b;
      op_sub:  value = a - b;
      op_and:  value = a & b;
      op_xor:  value = a ^ b;
      op_mul:  value = acc;
      op_li:   value = instr_q.operand.imm;
      default: value = '0;
    endcase
  end

  assign result.valid = done;
  assign result.slot  = slot_q;
  assign result.value = value;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      step   <= '0;
    end else if (issue.valid) begin
      active <= 1'b1;
      step   <= '0;
    end else if (done) begin
      active <= 1'b0;
    end else if (mul_run) begin
      step <= step + STEP_W'(1);
    end
  end

  // First multiply step is folded into the load
  always_ff @(posedge clock) begin
    if (issue.valid) begin
      instr_q <= issue.instr;
      slot_q  <= issue.slot;
      acc     <= issue.instr.operand.ops.opb[0] ?
                 VAL_W'(issue.instr.operand.ops.opa) : '0;
      mcand   <= VAL_W'(issue.instr.operand.ops.opa) << 1;
      mplier  <= issue.instr.operand.ops.opb >> 1;
    end else if (mul_run) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

endmodule

// File: logic/dispatch.sv
module dispatch
  import pipe_pkg::*;
(
  input                                 clock,
  input                                 rst_n,

  // from outside
  input                                 in_valid,
  input  instr_t                        in_instr,

  // from lanes and ROB
  input         [NUM_LANES-1:0]         lane_busy,
  input                                 rob_full,

  // to outside, ROB and lanes
  output logic                          stall,
  output rob_alloc_t                    alloc,
  output lane_issue_t [NUM_LANES-1:0]   issue
);

  logic [SLOT_W-1:0]    tail;
  logic [NUM_LANES-1:0] lane_free;
  logic [NUM_LANES-1:0] grant;
  logic                 accept;

  assign lane_free = ~lane_busy;

  // Lowest set bit of the free mask
  assign grant = lane_free & (~lane_free + NUM_LANES'(1));

  assign stall  = rob_full | ~|lane_free;
  assign accept = in_valid & ~stall;

  assign alloc.valid = accept;
  assign alloc.slot  = tail;
  assign alloc.rd    = in_instr.rd;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      issue[i].valid = accept & grant[i];
      issue[i].slot  = tail;
      issue[i].instr = in_instr;
    end
  end

  // Tail wraps with the slot width
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tail <= '0;
    end else if (accept) begin
      tail <= tail + SLOT_W'(1);
    end
  end

endmodule

// File: logic/pipe_pkg.sv
package pipe_pkg;

  // Machine sizes
  localparam int NUM_LANES = 4;
  localparam int ROB_DEPTH = 8;
  localparam int SLOT_W    = $clog2(ROB_DEPTH);
  localparam int REG_W     = 5;
  localparam int VAL_W     = 16;
  localparam int OPND_W    = 8;

  // Shift-add multiplier walks one operand bit per step
  localparam int MUL_STEPS = OPND_W;
  localparam int STEP_W    = $clog2(MUL_STEPS);

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_and = 4'd2,
    op_xor = 4'd3,
    op_mul = 4'd4,
    op_li  = 4'd5
  } op_t;

  typedef struct packed {
    logic [OPND_W-1:0] opa;
    logic [OPND_W-1:0] opb;
  } byte_ops_t;

  // Operand field, two bytes or one immediate
  typedef union packed {
    byte_ops_t         ops;
    logic [VAL_W-1:0]  imm;
  } operand_u;

  typedef struct packed {
    op_t               opcode;
    logic [REG_W-1:0]  rd;
    logic [6:0]        rsvd;
    operand_u          operand;
  } instr_t;

  typedef struct packed {
    logic              valid;
    logic [SLOT_W-1:0] slot;
    instr_t            instr;
  } lane_issue_t;

  typedef struct packed {
    logic              valid;
    logic [SLOT_W-1:0] slot;
    logic [VAL_W-1:0]  value;
  } lane_result_t;

  typedef struct packed {
    logic              valid;
    logic [SLOT_W-1:0] slot;
    logic [REG_W-1:0]  rd;
  } rob_alloc_t;

  typedef struct packed {
    logic              valid;
    logic [REG_W-1:0]  rd;
    logic [VAL_W-1:0]  value;
  } retire_t;

endpackage
